/* include/ps2_host_tasks.svh */
// Host-side PS/2 tasks for the testbench
// Include inside the testbench module. Each task clocks a keyboard frame
// onto the pins passed by reference and leaves both pins idle high
// The bit rate is far below the system clock so the synchroniser sees
// every edge
`ifndef PS2_HOST_TASKS_SVH
`define PS2_HOST_TASKS_SVH

localparam int PS2_HALF_NS = 2000;

// One frame: start, 8 data bits LSB first, odd parity, stop
task automatic ps2_send_byte(ref logic clk_pin, ref logic data_pin,
	input logic [7:0] code, input bit bad_parity);
	logic [10:0] frame;
	frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
	for (int i = 0; i < 11; i++) begin
		data_pin = frame[i];
		#(PS2_HALF_NS);
		clk_pin = 1'b0;
		#(PS2_HALF_NS);
		clk_pin = 1'b1;
	end
	data_pin = 1'b1;
	#(4 * PS2_HALF_NS);
endtask

// Make or break of one key, with the E0 prefix for arrow keys
task automatic ps2_send_key(ref logic clk_pin, ref logic data_pin,
	input logic [7:0] code, input bit extended, input bit brk);
	if (extended) begin
		ps2_send_byte(clk_pin, data_pin, arcade_pkg::SC_EXT, 1'b0);
	end
	if (brk) begin
		ps2_send_byte(clk_pin, data_pin, arcade_pkg::SC_BREAK, 1'b0);
	end
	ps2_send_byte(clk_pin, data_pin, code, 1'b0);
endtask

`endif

/* bench/tb_platform_glue.sv */
// Testbench for the arcade platform glue
// Drives PS/2 frames, joysticks, status bits, video and audio into the top
// level and compares every response with a model kept in the testbench
// Stimulus comes from an LCG with a fixed seed, so each run is identical
`timescale 1ns/1ps

module tb_platform_glue;
	import arcade_pkg::*;

	logic        clk_sys = 1'b0;
	logic        rst;
	logic        ps2_clk;
	logic        ps2_data;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [31:0] status;
	rgb3_t       game_rgb;
	logic        game_hs, game_vs, game_hblank, game_vblank;
	logic [3:0]  game_audio;

	player_input_t player;
	joy_dir_t      joy;
	vga_t          vga;
	logic          audio_l, audio_r;

	int unsigned rng_state = 32'd50763;
	int          error_count = 0;
	int          timeout_count = 0;

	// Keyboard model, one bit per key in the order fire, start1, coin, left,
	// right, down, up
	logic [6:0] kb_state;

	// Video model, one set of registers per pipeline stage
	rgb3_t      m_rgb;
	logic       m_blank, m_odd, m_hs, m_vs;
	logic [5:0] m_ch_r, m_ch_g, m_ch_b;
	logic       m_hs_d, m_vs_d;
	vga_t       m_vga;

	`include "ps2_host_tasks.svh"

	platform_glue_top dut0 (
		.clk_sys_i(clk_sys), .rst_i(rst),
		.ps2_clk_i(ps2_clk), .ps2_data_i(ps2_data),
		.joystick_0_i(joystick_0), .joystick_1_i(joystick_1), .status_i(status),
		.game_rgb_i(game_rgb), .game_hs_i(game_hs), .game_vs_i(game_vs),
		.game_hblank_i(game_hblank), .game_vblank_i(game_vblank),
		.game_audio_i(game_audio),
		.player_o(player), .joy_o(joy), .vga_o(vga),
		.audio_l_o(audio_l), .audio_r_o(audio_r)
	);

	always #50 clk_sys = ~clk_sys;

	//============================================================
	// Helpers
	//============================================================
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		// Fold the upper bits down, the low LCG bits repeat too quickly
		return rng_state ^ (rng_state >> 15);
	endfunction

	task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			$display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, actual,
				expected);
		end
	endtask

	// Scancode of each model key, bit 8 set for the arrow keys
	function automatic logic [8:0] key_scancode(input int idx);
		case (idx)
			0: return {1'b0, SC_SPACE};
			1: return {1'b0, SC_1};
			2: return {1'b0, SC_5};
			3: return {1'b1, SC_LEFT};
			4: return {1'b1, SC_RIGHT};
			5: return {1'b1, SC_DOWN};
			default: return {1'b1, SC_UP};
		endcase
	endfunction

	function automatic player_input_t expect_player(input logic [6:0] kb,
		input logic [7:0] j0, input logic [7:0] j1, input logic test);
		player_input_t p;
		p = '1;
		p.fire1  = ~(kb[0] | j0[4] | j1[4]);
		p.start1 = ~kb[1];
		p.c_coin = ~kb[2];
		p.test   = ~test;
		return p;
	endfunction

	function automatic joy_dir_t expect_joy(input logic [6:0] kb,
		input logic [7:0] j0, input logic [7:0] j1, input logic rotate);
		logic up, down, left, right;
		joy_dir_t d;
		left  = kb[3] | j0[1] | j1[1];
		right = kb[4] | j0[0] | j1[0];
		down  = kb[5] | j0[2] | j1[2];
		up    = kb[6] | j0[3] | j1[3];
		if (rotate) begin
			d.up    = ~right;
			d.down  = ~left;
			d.left  = ~up;
			d.right = ~down;
		end else begin
			d.up    = ~up;
			d.down  = ~down;
			d.left  = ~left;
			d.right = ~right;
		end
		return d;
	endfunction

	// Colour expansion with blanking and scanline dimming, mode 3 acts as 50%
	function automatic logic [5:0] shade(input logic [2:0] v, input logic blank,
		input logic odd, input logic [1:0] mode);
		logic [5:0] full;
		full = blank ? 6'd0 : {v, v};
		if (!odd || mode == SCAN_NONE) begin
			return full;
		end
		if (mode == SCAN_25) begin
			return full - (full >> 2);
		end
		return full >> 1;
	endfunction

	// One clock edge of the video model, last stage first
	task automatic video_model_step();
		m_vga.r  = m_ch_r;
		m_vga.g  = m_ch_g;
		m_vga.b  = m_ch_b;
		m_vga.hs = m_hs_d;
		m_vga.vs = m_vs_d;
		m_hs_d   = m_hs;
		m_vs_d   = m_vs;
		m_ch_r   = shade(m_rgb.r, m_blank, m_odd, status[4:3]);
		m_ch_g   = shade(m_rgb.g, m_blank, m_odd, status[4:3]);
		m_ch_b   = shade(m_rgb.b, m_blank, m_odd, status[4:3]);
		if (m_hs && !game_hs) begin
			m_odd = ~m_odd;
		end
		m_rgb   = game_rgb;
		m_blank = game_hblank | game_vblank;
		m_hs    = game_hs;
		m_vs    = game_vs;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		#5;
		rst = 1'b1;
		repeat (4) @(posedge clk_sys);
		#5;
		rst      = 1'b0;
		kb_state = '0;
		m_rgb    = '0;
		{m_blank, m_odd, m_hs, m_vs, m_hs_d, m_vs_d} = '0;
		{m_ch_r, m_ch_g, m_ch_b} = '0;
		m_vga    = '0;
	endtask

	// Waits until the control words reach the model, then checks them
	task automatic wait_for_controls(input string what);
		player_input_t exp_p;
		joy_dir_t      exp_j;
		int            n;
		exp_p = expect_player(kb_state, joystick_0, joystick_1, status[1]);
		exp_j = expect_joy(kb_state, joystick_0, joystick_1, status[2]);
		n = 0;
		while ((player !== exp_p || joy !== exp_j) && n < 20) begin
			@(posedge clk_sys);
			#5;
			n++;
		end
		if (n >= 20) begin
			timeout_count++;
			$display("Timeout: control outputs did not settle after %s", what);
		end
		compare_values(player, exp_p, {"player_o after ", what});
		compare_values(joy, exp_j, {"joy_o after ", what});
	endtask

	//============================================================
	// Test sequence
	//============================================================
	initial begin
		logic [31:0] r;
		logic [8:0]  sc;
		logic        brk;
		logic [3:0]  sample;
		int          idx;
		int          ones;
		int          lr_mismatch;

		rst         = 1'b1;
		ps2_clk     = 1'b1;
		ps2_data    = 1'b1;
		joystick_0  = '0;
		joystick_1  = '0;
		status      = '0;
		game_rgb    = '0;
		game_hs     = 1'b0;
		game_vs     = 1'b0;
		game_hblank = 1'b0;
		game_vblank = 1'b0;
		game_audio  = '0;

		apply_reset();
		compare_values(player, 10'h3FF, "player_o after reset");
		compare_values(joy, 4'hF, "joy_o after reset");
		compare_values(vga, '0, "vga_o after reset");
		compare_values({audio_l, audio_r}, 2'b00, "audio after reset");

		// Keyboard, every key pressed once first, then random traffic
		for (int i = 0; i < 40; i++) begin
			r   = next_rand();
			idx = (i < 7) ? i : (r[15:8] % 7);
			sc  = key_scancode(idx);
			if (i >= 7 && r[3:0] < 4'd3) begin
				// A released plain key must stay released after a make with bad parity
				idx = r[15:8] % 3;
				sc  = key_scancode(idx);
				ps2_send_key(ps2_clk, ps2_data, sc[7:0], 1'b0, 1'b1);
				kb_state[idx] = 1'b0;
				ps2_send_byte(ps2_clk, ps2_data, sc[7:0], 1'b1);
				@(posedge clk_sys);
				#5;
				wait_for_controls("bad parity frame");
			end else begin
				brk = (i >= 7) && r[4];
				ps2_send_key(ps2_clk, ps2_data, sc[7:0], sc[8], brk);
				kb_state[idx] = ~brk;
				@(posedge clk_sys);
				#5;
				wait_for_controls("key frame");
			end
		end

		// Joysticks and rotation, registered one cycle
		for (int i = 0; i < 200; i++) begin
			r          = next_rand();
			joystick_0 = r[7:0];
			r          = next_rand();
			joystick_1 = r[7:0];
			status     = next_rand();
			@(posedge clk_sys);
			#5;
			compare_values(player, expect_player(kb_state, joystick_0, joystick_1,
				status[1]), "player_o with joysticks");
			compare_values(joy, expect_joy(kb_state, joystick_0, joystick_1, status[2]),
				"joy_o with joysticks");
		end
		joystick_0 = '0;
		joystick_1 = '0;
		status     = '0;

		// Video path, checked every cycle against the stage model
		apply_reset();
		for (int c = 0; c < 2000; c++) begin
			@(posedge clk_sys);
			video_model_step();
			#5;
			compare_values(vga, m_vga, "vga_o");
			r           = next_rand();
			game_rgb    = r[8:0];
			game_hs     = r[9];
			game_vs     = r[10] & r[11];
			game_hblank = r[12] & r[13];
			game_vblank = r[14] & r[15] & r[16];
			status[4:3] = r[18:17];
		end

		// Audio, density of ones over one full accumulator period
		r          = next_rand();
		sample     = r[7:4];
		game_audio = sample;
		apply_reset();
		ones        = 0;
		lr_mismatch = 0;
		for (int c = 0; c < 65536; c++) begin
			@(posedge clk_sys);
			#5;
			if (audio_l === 1'b1) begin
				ones++;
			end
			if (audio_r !== audio_l) begin
				lr_mismatch++;
			end
		end
		compare_values(ones, {sample, sample, sample, sample}, "ones on audio_l_o");
		compare_values(lr_mismatch, 0, "cycles with audio_r_o unlike audio_l_o");

		$display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* src/arcade_pkg.sv */
// Shared definitions for the arcade platform glue
// Holds key indices, PS/2 scancodes, the DAC width, scanline modes and the
// packed structs that carry controls and video between the blocks
// Compile before every other source file

package arcade_pkg;

	// Key vector from the keyboard decoder, active high
	localparam int KEY_COUNT  = 10;
	localparam int KEY_FIRE   = 0;
	localparam int KEY_START1 = 1;
	localparam int KEY_COIN   = 3;
	localparam int KEY_LEFT   = 4;
	localparam int KEY_RIGHT  = 5;
	localparam int KEY_DOWN   = 6;
	localparam int KEY_UP     = 7;

	// Plain set 2 scancodes
	localparam logic [7:0] SC_SPACE = 8'h29;
	localparam logic [7:0] SC_1     = 8'h16;
	localparam logic [7:0] SC_5     = 8'h2E;
	// Arrow codes, valid only after the E0 prefix
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_EXT   = 8'hE0;
	localparam logic [7:0] SC_BREAK = 8'hF0;

	localparam int DAC_WIDTH = 16;

	typedef enum logic [1:0] {
		SCAN_NONE = 2'd0,
		SCAN_25   = 2'd1,
		SCAN_50   = 2'd2
	} scan_mode_t;

	// Both control words are active low, as the game expects them
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
	} joy_dir_t;

	typedef struct packed {
		logic r_coin;
		logic c_coin;
		logic l_coin;
		logic test;
		logic cocktail;
		logic slam;
		logic start2;
		logic start1;
		logic fire2;
		logic fire1;
	} player_input_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} rgb3_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_t;

endpackage

/* src/audio_dac.sv */
// First-order sigma-delta DAC with a one-bit output stream
// Each cycle the sample is added to the accumulator; the carry out is the
// output bit, so the density of ones follows the sample value
`timescale 1ns/1ps

module audio_dac (
	input  logic                             clk_sys_i,
	input  logic                             rst_i,
	input  logic [arcade_pkg::DAC_WIDTH-1:0] sample_i,
	output logic                             dac_o
);
	import arcade_pkg::*;

	logic [DAC_WIDTH:0] acc_q;
	logic [DAC_WIDTH:0] acc_next;

	assign acc_next = {1'b0, acc_q[DAC_WIDTH-1:0]} + {1'b0, sample_i};

	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			// Start one below wrap so the first full window holds exactly
			// sample_i ones, whichever cycle the window starts on
			acc_q <= {1'b0, {DAC_WIDTH{1'b1}}};
		end else begin
			acc_q <= acc_next;
		end
	end

	assign dac_o = acc_q[DAC_WIDTH];

endmodule

/* src/color_channel.sv */
// One colour channel of the VGA path, instantiated once per colour
// Expands 3 bits to 6, blacks out blanking and dims odd lines according
// to the selected scanline mode; the result is registered
`timescale 1ns/1ps

module color_channel (
	input  logic                   clk_sys_i,
	input  logic                   rst_i,
	input  logic [2:0]             value_i,
	input  logic                   blank_i,
	input  logic                   odd_line_i,
	input  arcade_pkg::scan_mode_t mode_i,
	output logic [5:0]             value_o
);
	import arcade_pkg::*;

	logic [5:0] expanded;
	logic [5:0] dimmed;

	always_comb begin
		expanded = blank_i ? 6'd0 : {value_i, value_i};
		dimmed   = expanded;
		if (odd_line_i) begin
			case (mode_i)
				SCAN_25: dimmed = expanded - (expanded >> 2);
				SCAN_50: dimmed = expanded >> 1;
				default: dimmed = expanded;
			endcase
		end
	end

	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			value_o <= '0;
		end else begin
			value_o <= dimmed;
		end
	end

	a_blank_black: assert property (@(posedge clk_sys_i) disable iff (rst_i)
		blank_i |=> (value_o == 6'd0));

endmodule

/* src/control_mapper.sv */
// Merges the keyboard key vector with both board joysticks
// Joystick bits are active high (0 right, 1 left, 2 down, 3 up, 4 fire),
// the outputs are the game's active-low player-input and joystick words
`timescale 1ns/1ps

module control_mapper (
	input  logic                             clk_sys_i,
	input  logic                             rst_i,
	input  logic [arcade_pkg::KEY_COUNT-1:0] keys_i,
	input  logic [7:0]                       joystick_0_i,
	input  logic [7:0]                       joystick_1_i,
	input  logic                             rotate_i,
	input  logic                             test_i,
	output arcade_pkg::player_input_t        player_o,
	output arcade_pkg::joy_dir_t             joy_o
);
	import arcade_pkg::*;

	logic up_a, down_a, left_a, right_a, fire_a;

	// Active high requests from any source
	always_comb begin
		up_a    = keys_i[KEY_UP]    | joystick_0_i[3] | joystick_1_i[3];
		down_a  = keys_i[KEY_DOWN]  | joystick_0_i[2] | joystick_1_i[2];
		left_a  = keys_i[KEY_LEFT]  | joystick_0_i[1] | joystick_1_i[1];
		right_a = keys_i[KEY_RIGHT] | joystick_0_i[0] | joystick_1_i[0];
		fire_a  = keys_i[KEY_FIRE]  | joystick_0_i[4] | joystick_1_i[4];
	end

	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			player_o <= '1;
			joy_o    <= '1;
		end else begin
			// Rotated cabinet turns the controls a quarter turn
			joy_o.up    <= ~(rotate_i ? right_a : up_a);
			joy_o.down  <= ~(rotate_i ? left_a  : down_a);
			joy_o.left  <= ~(rotate_i ? up_a    : left_a);
			joy_o.right <= ~(rotate_i ? down_a  : right_a);

			player_o.fire1    <= ~fire_a;
			player_o.start1   <= ~keys_i[KEY_START1];
			player_o.c_coin   <= ~keys_i[KEY_COIN];
			player_o.test     <= ~test_i;
			// No second player or tilt switch on this board
			player_o.fire2    <= 1'b1;
			player_o.start2   <= 1'b1;
			player_o.l_coin   <= 1'b1;
			player_o.r_coin   <= 1'b1;
			player_o.slam     <= 1'b1;
			player_o.cocktail <= 1'b1;
		end
	end

endmodule

/* src/platform_glue_top.sv */
// Platform glue around the arcade game core
// Connects the PS/2 decoder, the control mapper, the three-stage video path
// and the sigma-delta audio DAC; configuration arrives on status_i
// (bit 1 test, bit 2 rotate, bits 4:3 scanline mode)
`timescale 1ns/1ps

module platform_glue_top (
	input  logic                      clk_sys_i,
	input  logic                      rst_i,
	input  logic                      ps2_clk_i,
	input  logic                      ps2_data_i,
	input  logic [7:0]                joystick_0_i,
	input  logic [7:0]                joystick_1_i,
	input  logic [31:0]               status_i,
	input  arcade_pkg::rgb3_t         game_rgb_i,
	input  logic                      game_hs_i,
	input  logic                      game_vs_i,
	input  logic                      game_hblank_i,
	input  logic                      game_vblank_i,
	input  logic [3:0]                game_audio_i,
	output arcade_pkg::player_input_t player_o,
	output arcade_pkg::joy_dir_t      joy_o,
	output arcade_pkg::vga_t          vga_o,
	output logic                      audio_l_o,
	output logic                      audio_r_o
);
	import arcade_pkg::*;

	logic [KEY_COUNT-1:0] keys;
	scan_mode_t           scan_mode;
	rgb3_t                gate_rgb;
	logic                 gate_blank, gate_odd, gate_hs, gate_vs;
	logic [2:0]           chan_in [3];
	logic [5:0]           chan_out [3];
	logic [DAC_WIDTH-1:0] audio_wide;

	// Mode 11 has no effect of its own here and falls back to 50% dimming
	assign scan_mode = (status_i[4:3] == 2'b11) ? SCAN_50 : scan_mode_t'(status_i[4:3]);

	//============================================================
	// Controls
	//============================================================
	ps2_scan_decoder ps2_scan_decoder (.clk_sys_i(clk_sys_i), .rst_i(rst_i),
		.ps2_clk_i(ps2_clk_i), .ps2_data_i(ps2_data_i), .keys_o(keys));

	control_mapper control_mapper (.clk_sys_i(clk_sys_i), .rst_i(rst_i),
		.keys_i(keys), .joystick_0_i(joystick_0_i), .joystick_1_i(joystick_1_i),
		.rotate_i(status_i[2]), .test_i(status_i[1]),
		.player_o(player_o), .joy_o(joy_o));

	//============================================================
	// Video
	//============================================================
	video_timing_gate video_timing_gate (.clk_sys_i(clk_sys_i), .rst_i(rst_i),
		.rgb_i(game_rgb_i), .hs_i(game_hs_i), .vs_i(game_vs_i),
		.hblank_i(game_hblank_i), .vblank_i(game_vblank_i),
		.rgb_o(gate_rgb), .blank_o(gate_blank), .odd_line_o(gate_odd),
		.hs_o(gate_hs), .vs_o(gate_vs));

	assign chan_in[0] = gate_rgb.r;
	assign chan_in[1] = gate_rgb.g;
	assign chan_in[2] = gate_rgb.b;

	for (genvar ch = 0; ch < 3; ch++) begin : g_chan
		color_channel color_channel (.clk_sys_i(clk_sys_i), .rst_i(rst_i),
			.value_i(chan_in[ch]), .blank_i(gate_blank), .odd_line_i(gate_odd),
			.mode_i(scan_mode), .value_o(chan_out[ch]));
	end

	vga_output_stage vga_output_stage (.clk_sys_i(clk_sys_i), .rst_i(rst_i),
		.r_i(chan_out[0]), .g_i(chan_out[1]), .b_i(chan_out[2]),
		.hs_i(gate_hs), .vs_i(gate_vs), .vga_o(vga_o));

	//============================================================
	// Audio, the 4-bit sample repeated up to full scale
	//============================================================
	assign audio_wide = {(DAC_WIDTH / 4){game_audio_i}};

	audio_dac audio_dac (.clk_sys_i(clk_sys_i), .rst_i(rst_i),
		.sample_i(audio_wide), .dac_o(audio_l_o));

	assign audio_r_o = audio_l_o;

endmodule

/* src/ps2_scan_decoder.sv */
// PS/2 keyboard receiver that keeps one held/released bit per mapped key
// Frames are sampled on falling edges of the synchronised keyboard clock;
// a bad frame is dropped and unknown codes leave the key vector alone
`timescale 1ns/1ps

module ps2_scan_decoder (
	input  logic                            clk_sys_i,
	input  logic                            rst_i,
	input  logic                            ps2_clk_i,
	input  logic                            ps2_data_i,
	output logic [arcade_pkg::KEY_COUNT-1:0] keys_o
);
	import arcade_pkg::*;

	logic       clk_meta, clk_sync, clk_prev;
	logic       data_meta, data_sync;
	logic       clk_fall;
	logic [3:0] bit_cnt;
	// Start bit in bit 0, data in 8:1, parity in bit 9
	logic [9:0] shift_q;
	logic       frame_ok;
	logic [7:0] code;
	logic       ext_q, brk_q;

	//============================================================
	// Pin synchronisers and edge detect
	//============================================================
	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			clk_meta  <= 1'b1;
			clk_sync  <= 1'b1;
			clk_prev  <= 1'b1;
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end else begin
			clk_meta  <= ps2_clk_i;
			clk_sync  <= clk_meta;
			clk_prev  <= clk_sync;
			data_meta <= ps2_data_i;
			data_sync <= data_meta;
		end
	end

	assign clk_fall = clk_prev & ~clk_sync;

	//============================================================
	// Frame assembly
	//============================================================
	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			bit_cnt <= '0;
		end else if (clk_fall) begin
			bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_sys_i) begin
		if (clk_fall && bit_cnt != 4'd10) begin
			shift_q <= {data_sync, shift_q[9:1]};
		end
	end

	// The stop bit is the live data sample, odd parity covers data and parity
	assign frame_ok = clk_fall && (bit_cnt == 4'd10) && data_sync &&
	                  !shift_q[0] && (^shift_q[9:1]);
	assign code = shift_q[8:1];

	//============================================================
	// Scancode decode
	//============================================================
	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			keys_o <= '0;
			ext_q  <= 1'b0;
			brk_q  <= 1'b0;
		end else if (frame_ok) begin
			if (code == SC_EXT) begin
				ext_q <= 1'b1;
			end else if (code == SC_BREAK) begin
				brk_q <= 1'b1;
			end else begin
				// Any other byte ends the prefix sequence
				ext_q <= 1'b0;
				brk_q <= 1'b0;
				if (ext_q) begin
					case (code)
						SC_LEFT:  keys_o[KEY_LEFT]  <= ~brk_q;
						SC_RIGHT: keys_o[KEY_RIGHT] <= ~brk_q;
						SC_DOWN:  keys_o[KEY_DOWN]  <= ~brk_q;
						SC_UP:    keys_o[KEY_UP]    <= ~brk_q;
						default: ;
					endcase
				end else begin
					case (code)
						SC_SPACE: keys_o[KEY_FIRE]   <= ~brk_q;
						SC_1:     keys_o[KEY_START1] <= ~brk_q;
						SC_5:     keys_o[KEY_COIN]   <= ~brk_q;
						default: ;
					endcase
				end
			end
		end
	end

	a_bit_cnt_range: assert property (@(posedge clk_sys_i) disable iff (rst_i)
		bit_cnt <= 4'd10);

endmodule

/* src/vga_output_stage.sv */
// Last stage of the video path
// Gathers the three channel values and the syncs into one VGA word; the
// syncs get one more cycle so they stay aligned with the channel registers
`timescale 1ns/1ps

module vga_output_stage (
	input  logic             clk_sys_i,
	input  logic             rst_i,
	input  logic [5:0]       r_i,
	input  logic [5:0]       g_i,
	input  logic [5:0]       b_i,
	input  logic             hs_i,
	input  logic             vs_i,
	output arcade_pkg::vga_t vga_o
);

	logic hs_d, vs_d;

	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			hs_d  <= 1'b0;
			vs_d  <= 1'b0;
			vga_o <= '0;
		end else begin
			hs_d     <= hs_i;
			vs_d     <= vs_i;
			vga_o.r  <= r_i;
			vga_o.g  <= g_i;
			vga_o.b  <= b_i;
			vga_o.hs <= hs_d;
			vga_o.vs <= vs_d;
		end
	end

endmodule

/* src/video_timing_gate.sv */
// First stage of the video path
// Registers the game pixel and syncs, merges both blanking inputs and keeps
// the odd/even line parity used by the scanline effect
`timescale 1ns/1ps

module video_timing_gate (
	input  logic              clk_sys_i,
	input  logic              rst_i,
	input  arcade_pkg::rgb3_t rgb_i,
	input  logic              hs_i,
	input  logic              vs_i,
	input  logic              hblank_i,
	input  logic              vblank_i,
	output arcade_pkg::rgb3_t rgb_o,
	output logic              blank_o,
	output logic              odd_line_o,
	output logic              hs_o,
	output logic              vs_o
);

	always_ff @(posedge clk_sys_i) begin
		if (rst_i) begin
			rgb_o      <= '0;
			blank_o    <= 1'b0;
			odd_line_o <= 1'b0;
			hs_o       <= 1'b0;
			vs_o       <= 1'b0;
		end else begin
			rgb_o   <= rgb_i;
			blank_o <= hblank_i | vblank_i;
			hs_o    <= hs_i;
			vs_o    <= vs_i;
			// hs_o still holds the previous sample, so this is a falling edge
			if (hs_o && !hs_i) begin
				odd_line_o <= ~odd_line_o;
			end
		end
	end

endmodule

/* verilog.f */
+incdir+include
src/arcade_pkg.sv
src/ps2_scan_decoder.sv
src/control_mapper.sv
src/video_timing_gate.sv
src/color_channel.sv
src/vga_output_stage.sv
src/audio_dac.sv
src/platform_glue_top.sv
bench/tb_platform_glue.sv
